//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       ?= fcvt_tb
FILELIST  ?= src.f

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- hw/fcvt_ctrl.sv
// Four-phase req/ack controller of the conversion unit.
// Captures opcode and operand when a request is seen in idle, pulses the
// advance enable of each pipeline stage once, and holds ack high with the
// result until the client drops its request.

`timescale 1ns/1ps
`default_nettype none

module fcvt_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_i,
  input  fcvt_pkg::cvt_op_e op_i,
  input  logic [31:0]       operand_i,
  input  logic              done_i,
  output logic              ack_o,
  output fcvt_pkg::cvt_op_e op_q_o,
  output logic [31:0]       operand_q_o,
  output logic              start_f2i_o,
  output logic              start_i2f_o,
  output logic              adv1_o,
  output logic              adv2_o
);

  import fcvt_pkg::*;

  ctrl_state_e state_q;

  // idle -> stage1 (adv1) -> stage2 (adv2, wait done) -> ack
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= ST_IDLE;
      adv1_o  <= 1'b0;
      adv2_o  <= 1'b0;
    end else begin
      adv1_o <= 1'b0;
      adv2_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_STAGE1;
            adv1_o  <= 1'b1;
          end
        end
        ST_STAGE1: begin
          state_q <= ST_STAGE2;
          adv2_o  <= 1'b1;
        end
        ST_STAGE2: begin
          if (done_i) begin
            state_q <= ST_ACK;
          end
        end
        // held here as long as the client keeps req high
        ST_ACK: begin
          if (!req_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // operands are sampled once per request
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && req_i) begin
      op_q_o      <= op_i;
      operand_q_o <= operand_i;
    end
  end

  assign ack_o       = (state_q == ST_ACK);
  assign start_i2f_o = (op_q_o == OP_I2F);
  assign start_f2i_o = (op_q_o != OP_I2F);

  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack_o) |-> req_i);

  // the rounding stage answers the cycle after its advance
  a_done_after_adv2: assert property (@(posedge clk) disable iff (rst)
    adv2_o |=> (done_i && state_q == ST_STAGE2));

endmodule

`default_nettype wire

//--- hw/fcvt_f2i.sv
// First pipeline stage of float to integer conversion.
// Turns the unpacked exponent into right/left shift amounts for the
// rounding stage and pre-detects overflow and NaN. Everything loads on the
// advance enable; the ready bit is the only reset-cleared state.

`timescale 1ns/1ps
`default_nettype none

module fcvt_f2i (
  input  logic        clk,
  input  logic        rst,
  input  logic        adv_i,
  input  logic        start_i,
  input  logic        signa_i,
  input  logic [9:0]  exp10a_i,
  input  logic [23:0] fract24a_i,
  input  logic        snan_i,
  input  logic        qnan_i,
  output logic        f2i_rdy_o,
  output logic        f2i_sign_o,
  output logic [23:0] f2i_int24_o,
  output logic [4:0]  f2i_shr_o,
  output logic [3:0]  f2i_shl_o,
  output logic        f2i_ovf_o,
  output logic        f2i_snan_o,
  output logic        f2i_nan_o
);

  import fcvt_pkg::*;

  // binary point moved behind the mantissa lsb
  localparam logic [9:0] EXP_OFFS = EXP_BIAS + 10'd23;

  logic [9:0] exp10m;
  logic [9:0] shr_t;
  logic [4:0] shr;
  logic [3:0] shl;
  logic       shl_gt8;
  logic       shl_eq8;
  logic       ovf;

  // unbiased exponent of the integer lsb, negative means shift right
  assign exp10m = exp10a_i - EXP_OFFS;
  assign shr_t  = exp10m[9] ? (EXP_OFFS - exp10a_i) : 10'd0;

  // right shift clamps at 31, anything further is all sticky
  assign shr = (|shr_t[9:5]) ? 5'd31 : shr_t[4:0];
  // left shift clamps at 15, already far beyond int32 range
  assign shl = exp10m[9] ? 4'd0 : ((|exp10m[9:4]) ? 4'd15 : exp10m[3:0]);

  // shl of 8 puts the hidden one at bit 31
  // only -2^31 exactly fits there
  assign shl_gt8 = shl[3] & (|shl[2:0]);
  assign shl_eq8 = (shl == 4'd8);
  assign ovf     = shl_gt8 | (shl_eq8 & (~signa_i | (|fract24a_i[22:0])));

  //////////////////////////////
  // stage registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      // NaN converts to the positive limit
      f2i_sign_o  <= signa_i & ~(qnan_i | snan_i);
      f2i_int24_o <= fract24a_i;
      f2i_shr_o   <= shr;
      f2i_shl_o   <= shl;
      f2i_ovf_o   <= ovf;
      f2i_snan_o  <= snan_i;
      // quiet nan only
      f2i_nan_o   <= qnan_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      f2i_rdy_o <= 1'b0;
    end else if (adv_i) begin
      f2i_rdy_o <= start_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/fcvt_i2f.sv
// First pipeline stage of integer to float conversion.
// Takes the magnitude of a signed 32-bit integer, finds its leading one and
// registers the biased exponent plus the shift that brings the leading one
// to bit 23. The rounding stage applies the shift and rounds.

`timescale 1ns/1ps
`default_nettype none

module fcvt_i2f (
  input  logic        clk,
  input  logic        rst,
  input  logic        adv_i,
  input  logic        start_i,
  input  logic [31:0] int_i,
  output logic        i2f_rdy_o,
  output logic        i2f_sign_o,
  output logic [31:0] i2f_mag_o,
  output logic [9:0]  i2f_exp10_o,
  output logic [4:0]  i2f_shr_o,
  output logic [4:0]  i2f_shl_o,
  output logic        i2f_zero_o
);

  import fcvt_pkg::*;

  logic        sign;
  logic [31:0] mag;
  logic        zero;
  logic [5:0]  clz;
  logic [9:0]  exp10;
  logic [4:0]  shr;
  logic [4:0]  shl;

  // two's complement magnitude, -2^31 stays 0x80000000 as unsigned
  assign sign = int_i[31];
  assign mag  = sign ? (~int_i + 32'd1) : int_i;
  assign zero = (int_i == 32'd0);

  // priority search, the highest set bit wins
  always_comb begin
    clz = 6'd32;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) begin
        clz = 6'(31 - i);
      end
    end
  end

  // leading one at bit 31-clz has weight 2^(31-clz)
  assign exp10 = EXP_BIAS + 10'd31 - {4'd0, clz};

  //////////////////////////////
  // normalize to bit 23
  //////////////////////////////

  // more than 24 significant bits need a right shift (at most 8)
  assign shr = (clz < 6'd8) ? 5'(6'd8 - clz) : 5'd0;
  // narrower values move up, zero is left alone
  assign shl = (clz < 6'd8 || zero) ? 5'd0 : 5'(clz - 6'd8);

  always_ff @(posedge clk) begin
    if (adv_i) begin
      i2f_sign_o  <= sign;
      i2f_mag_o   <= mag;
      i2f_exp10_o <= exp10;
      i2f_shr_o   <= shr;
      i2f_shl_o   <= shl;
      i2f_zero_o  <= zero;
    end
  end

  // ready marks which first stage holds the live item
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      i2f_rdy_o <= 1'b0;
    end else if (adv_i) begin
      i2f_rdy_o <= start_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/fcvt_pkg.sv
// Shared types and constants of the binary32 <-> int32 conversion unit.
// Holds the opcode and controller-state enums and the format constants.
// Design files import it inside the module body.
// Port declarations use scoped names.

`default_nettype none

package fcvt_pkg;

  //////////////////////////////
  // opcodes
  //////////////////////////////

  // conversion selected by the client with each request
  typedef enum logic [1:0] {
    OP_F2I_RNE = 2'd0,
    OP_F2I_RTZ = 2'd1,
    OP_I2F     = 2'd2
  } cvt_op_e;

  // handshake controller states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_STAGE1 = 2'd1,
    ST_STAGE2 = 2'd2,
    ST_ACK    = 2'd3
  } ctrl_state_e;

  //////////////////////////////
  // format constants
  //////////////////////////////

  // binary32 exponent bias, widened to the internal 10-bit exponent
  localparam logic [9:0] EXP_BIAS = 10'd127;

  // saturation results of float to integer
  localparam logic [31:0] F2I_POS_MAX = 32'h7FFF_FFFF;
  localparam logic [31:0] F2I_NEG_MAX = 32'h8000_0000;

endpackage

`default_nettype wire

//--- hw/fcvt_rnd.sv
// Second pipeline stage shared by both conversion directions.
// Applies the shifts prepared by the first stage, rounds, saturates and packs
// the result, and raises invalid/inexact/overflow. The done pulse follows
// the advance by one cycle and tells the controller the result is valid.

`timescale 1ns/1ps
`default_nettype none

module fcvt_rnd (
  input  logic              clk,
  input  logic              rst,
  input  logic              adv_i,
  input  fcvt_pkg::cvt_op_e op_i,
  input  logic              f2i_rdy_i,
  input  logic              f2i_sign_i,
  input  logic [23:0]       f2i_int24_i,
  input  logic [4:0]        f2i_shr_i,
  input  logic [3:0]        f2i_shl_i,
  input  logic              f2i_ovf_i,
  input  logic              f2i_snan_i,
  input  logic              f2i_nan_i,
  input  logic              i2f_rdy_i,
  input  logic              i2f_sign_i,
  input  logic [31:0]       i2f_mag_i,
  input  logic [9:0]        i2f_exp10_i,
  input  logic [4:0]        i2f_shr_i,
  input  logic [4:0]        i2f_shl_i,
  input  logic              i2f_zero_i,
  output logic              done_o,
  output logic [31:0]       result_o,
  output logic              invalid_o,
  output logic              inexact_o,
  output logic              overflow_o
);

  import fcvt_pkg::*;

  logic [55:0] f2i_ext;
  logic [31:0] f2i_mag;
  logic        f2i_grd;
  logic        f2i_stk;
  logic        f2i_inc;
  logic [31:0] f2i_rnd;
  logic        f2i_any_nan;
  logic        f2i_sat;
  logic [31:0] f2i_res;
  logic [31:0] i2f_norm;
  logic        i2f_grd;
  logic        i2f_stk;
  logic        i2f_inc;
  logic [24:0] i2f_m25;
  logic [7:0]  i2f_exp8;
  logic [31:0] i2f_res;

  //////////////////////////////
  // float to integer
  //////////////////////////////

  // 32 extra bits below the lsb keep guard and sticky for shr up to 31
  assign f2i_ext = {f2i_int24_i, 32'd0} >> f2i_shr_i;
  // shr and shl are never both nonzero
  assign f2i_mag = {8'd0, f2i_ext[55:32]} << f2i_shl_i;
  assign f2i_grd = f2i_ext[31];
  assign f2i_stk = |f2i_ext[30:0];

  // round half to even, truncation never increments
  assign f2i_inc = (op_i != OP_F2I_RTZ) & f2i_grd & (f2i_stk | f2i_mag[0]);
  assign f2i_rnd = f2i_mag + {31'd0, f2i_inc};

  assign f2i_any_nan = f2i_nan_i | f2i_snan_i;
  assign f2i_sat     = f2i_ovf_i | f2i_any_nan;
  assign f2i_res     = f2i_sat ? (f2i_sign_i ? F2I_NEG_MAX : F2I_POS_MAX)
                     : (f2i_sign_i ? (~f2i_rnd + 32'd1) : f2i_rnd);

  //////////////////////////////
  // integer to float
  //////////////////////////////

  // leading one lands on bit 31, the 8 bits below it hold guard and sticky
  assign i2f_norm = 32'(({i2f_mag_i, 8'd0} >> i2f_shr_i) << i2f_shl_i);
  assign i2f_grd  = i2f_norm[7];
  assign i2f_stk  = |i2f_norm[6:0];
  assign i2f_inc  = i2f_grd & (i2f_stk | i2f_norm[8]);
  assign i2f_m25  = {1'b0, i2f_norm[31:8]} + {24'd0, i2f_inc};

  // a carry out of the mantissa bumps the exponent, fraction is then zero
  assign i2f_exp8 = 8'(i2f_exp10_i + {9'd0, i2f_m25[24]});
  assign i2f_res  = i2f_zero_i ? 32'd0 : {i2f_sign_i, i2f_exp8, i2f_m25[22:0]};

  //////////////////////////////
  // output registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      if (i2f_rdy_i) begin
        result_o   <= i2f_res;
        invalid_o  <= 1'b0;
        inexact_o  <= i2f_grd | i2f_stk;
        overflow_o <= 1'b0;
      end else begin
        result_o   <= f2i_res;
        invalid_o  <= f2i_sat;
        inexact_o  <= ~f2i_sat & (f2i_grd | f2i_stk);
        overflow_o <= f2i_ovf_i & ~f2i_any_nan;
      end
    end
  end

  // one-cycle pulse after an advance that carried an item
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done_o <= 1'b0;
    end else begin
      done_o <= adv_i & (f2i_rdy_i | i2f_rdy_i);
    end
  end

  // the two first stages never hold an item at once
  a_one_stage_rdy: assert property (@(posedge clk) disable iff (rst)
    !(f2i_rdy_i && i2f_rdy_i));

endmodule

`default_nettype wire

//--- hw/fcvt_top.sv
// Top level of the binary32 <-> int32 conversion unit.
// A client issues one conversion at a time over a four-phase req/ack
// handshake; result and flags are valid while ack_o is high.
// Connects controller, unpacker, both first stages and the rounding stage.

`timescale 1ns/1ps
`default_nettype none

module fcvt_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_i,
  input  fcvt_pkg::cvt_op_e op_i,
  input  logic [31:0]       operand_i,
  output logic              ack_o,
  output logic [31:0]       result_o,
  output logic              invalid_o,
  output logic              inexact_o,
  output logic              overflow_o
);

  import fcvt_pkg::*;

  cvt_op_e     op_q;
  logic [31:0] operand_q;
  logic        start_f2i;
  logic        start_i2f;
  logic        adv1;
  logic        adv2;
  logic        done;

  // unpacked operand
  logic        ua_sign;
  logic [9:0]  ua_exp10;
  logic [23:0] ua_fract24;
  logic        ua_snan;
  logic        ua_qnan;

  // float to integer stage 1
  logic        f2i_rdy;
  logic        f2i_sign;
  logic [23:0] f2i_int24;
  logic [4:0]  f2i_shr;
  logic [3:0]  f2i_shl;
  logic        f2i_ovf;
  logic        f2i_snan;
  logic        f2i_nan;

  // integer to float stage 1
  logic        i2f_rdy;
  logic        i2f_sign;
  logic [31:0] i2f_mag;
  logic [9:0]  i2f_exp10;
  logic [4:0]  i2f_shr;
  logic [4:0]  i2f_shl;
  logic        i2f_zero;

  fcvt_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .op_i        (op_i),
    .operand_i   (operand_i),
    .done_i      (done),
    .ack_o       (ack_o),
    .op_q_o      (op_q),
    .operand_q_o (operand_q),
    .start_f2i_o (start_f2i),
    .start_i2f_o (start_i2f),
    .adv1_o      (adv1),
    .adv2_o      (adv2)
  );

  // infinity and zero need no own bits here, the f2i shifts cover them
  fcvt_unpack u_unpack (
    .operand_i (operand_q),
    .sign_o    (ua_sign),
    .exp10_o   (ua_exp10),
    .fract24_o (ua_fract24),
    .snan_o    (ua_snan),
    .qnan_o    (ua_qnan),
    .inf_o     (),
    .zero_o    ()
  );

  fcvt_f2i u_f2i (
    .clk         (clk),
    .rst         (rst),
    .adv_i       (adv1),
    .start_i     (start_f2i),
    .signa_i     (ua_sign),
    .exp10a_i    (ua_exp10),
    .fract24a_i  (ua_fract24),
    .snan_i      (ua_snan),
    .qnan_i      (ua_qnan),
    .f2i_rdy_o   (f2i_rdy),
    .f2i_sign_o  (f2i_sign),
    .f2i_int24_o (f2i_int24),
    .f2i_shr_o   (f2i_shr),
    .f2i_shl_o   (f2i_shl),
    .f2i_ovf_o   (f2i_ovf),
    .f2i_snan_o  (f2i_snan),
    .f2i_nan_o   (f2i_nan)
  );

  fcvt_i2f u_i2f (
    .clk         (clk),
    .rst         (rst),
    .adv_i       (adv1),
    .start_i     (start_i2f),
    .int_i       (operand_q),
    .i2f_rdy_o   (i2f_rdy),
    .i2f_sign_o  (i2f_sign),
    .i2f_mag_o   (i2f_mag),
    .i2f_exp10_o (i2f_exp10),
    .i2f_shr_o   (i2f_shr),
    .i2f_shl_o   (i2f_shl),
    .i2f_zero_o  (i2f_zero)
  );

  fcvt_rnd u_rnd (
    .clk         (clk),
    .rst         (rst),
    .adv_i       (adv2),
    .op_i        (op_q),
    .f2i_rdy_i   (f2i_rdy),
    .f2i_sign_i  (f2i_sign),
    .f2i_int24_i (f2i_int24),
    .f2i_shr_i   (f2i_shr),
    .f2i_shl_i   (f2i_shl),
    .f2i_ovf_i   (f2i_ovf),
    .f2i_snan_i  (f2i_snan),
    .f2i_nan_i   (f2i_nan),
    .i2f_rdy_i   (i2f_rdy),
    .i2f_sign_i  (i2f_sign),
    .i2f_mag_i   (i2f_mag),
    .i2f_exp10_i (i2f_exp10),
    .i2f_shr_i   (i2f_shr),
    .i2f_shl_i   (i2f_shl),
    .i2f_zero_i  (i2f_zero),
    .done_o      (done),
    .result_o    (result_o),
    .invalid_o   (invalid_o),
    .inexact_o   (inexact_o),
    .overflow_o  (overflow_o)
  );

endmodule

`default_nettype wire

//--- hw/fcvt_unpack.sv
// Operand unpacker for the float-to-integer path.
// Splits a binary32 word into sign, 10-bit biased exponent and 24-bit mantissa
// and flags NaN kind, infinity and zero. Purely combinational.

`timescale 1ns/1ps
`default_nettype none

module fcvt_unpack (
  input  logic [31:0] operand_i,
  output logic        sign_o,
  output logic [9:0]  exp10_o,
  output logic [23:0] fract24_o,
  output logic        snan_o,
  output logic        qnan_o,
  output logic        inf_o,
  output logic        zero_o
);

  import fcvt_pkg::*;

  // all-ones exponent field marks infinity and NaN
  localparam logic [7:0] EXP_ALL_ONES = 8'(2 * EXP_BIAS + 10'd1);

  logic [7:0]  exp8;
  logic [22:0] fract23;
  logic        exp_zero;
  logic        exp_max;
  logic        fract_zero;

  // raw fields
  assign exp8    = operand_i[30:23];
  assign fract23 = operand_i[22:0];

  assign exp_zero   = (exp8 == 8'd0);
  assign exp_max    = (exp8 == EXP_ALL_ONES);
  assign fract_zero = (fract23 == 23'd0);

  assign sign_o = operand_i[31];

  // denormals share the scale of exponent 1, just without the hidden one
  assign exp10_o   = exp_zero ? 10'd1 : {2'b00, exp8};
  assign fract24_o = {~exp_zero, fract23};

  //////////////////////////////
  // classification
  //////////////////////////////

  // msb of the fraction tells quiet from signaling
  assign qnan_o = exp_max & fract23[22];
  assign snan_o = exp_max & ~fract23[22] & ~fract_zero;
  assign inf_o  = exp_max & fract_zero;
  assign zero_o = exp_zero & fract_zero;

endmodule

`default_nettype wire

//--- src.f
hw/fcvt_pkg.sv
hw/fcvt_unpack.sv
hw/fcvt_f2i.sv
hw/fcvt_i2f.sv
hw/fcvt_rnd.sv
hw/fcvt_ctrl.sv
hw/fcvt_top.sv
verif/fcvt_clkgen.sv
verif/fcvt_tb.sv

//--- verif/fcvt_clkgen.sv
// Clock and reset source for the conversion unit testbench.
// 20 ns clock, reset held high over the first two rising edges.

`timescale 1ns/1ps
`default_nettype none

module fcvt_clkgen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD_NS = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // async reset, released right after the second rising edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/fcvt_tb.sv
// Directed testbench of the binary32 <-> int32 conversion unit.
// Every request runs the full four-phase handshake, checks the ack timing
// and compares result and flags against fixed values or a real-number model.
// Flags are compared as {invalid, inexact, overflow}.

`timescale 1ns/1ps
`default_nettype none

module fcvt_tb;

  import fcvt_pkg::*;

  localparam int unsigned SEED = 32'h1010_beec;
  // req is sampled one edge after it is driven, ack follows three edges later
  localparam int ACK_RISE_EDGES = 4;
  localparam int ACK_FALL_EDGES = 1;
  localparam int ACK_TIMEOUT = 16;
  localparam int HOLD_CYCLES = 10;
  localparam int N_RAND = 40;
  // 22 directed requests plus the random ones of both directions
  localparam int N_CONV = 22 + 2 * N_RAND;
  localparam int WATCHDOG_CYCLES = 40 * N_CONV;
  localparam real INT_LIMIT = 2147483648.0;

  logic        clk;
  logic        rst;
  logic        req;
  cvt_op_e     op;
  logic [31:0] operand;
  logic        ack;
  logic [31:0] result;
  logic        invalid;
  logic        inexact;
  logic        overflow;
  logic [31:0] got_result;
  logic [2:0]  got_flags;

  fcvt_clkgen u_clkgen (
    .clk_o (clk),
    .rst_o (rst)
  );

  fcvt_top dut (
    .clk        (clk),
    .rst        (rst),
    .req_i      (req),
    .op_i       (op),
    .operand_i  (operand),
    .ack_o      (ack),
    .result_o   (result),
    .invalid_o  (invalid),
    .inexact_o  (inexact),
    .overflow_o (overflow)
  );

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_result(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error [%s]: result expected 0x%08h, actual 0x%08h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
    if (act !== exp) begin
      $display("** Error [%s]: flags inv/inx/ovf expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("** Error [%s]: ack edges expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic real scale_pow2(input real x, input int n);
    real y;
    y = x;
    if (n > 0) begin
      repeat (n) y = y * 2.0;
    end else begin
      repeat (-n) y = y / 2.0;
    end
    return y;
  endfunction

  // real value of the float, rounded by the opcode, saturated to int32
  function automatic logic [31:0] f2i_model(input logic [31:0] bits, input cvt_op_e cop,
                                            output logic [2:0] flags);
    logic [7:0] e;
    real        mag;
    real        fl;
    real        frac;
    longint     r;
    e = bits[30:23];
    flags = 3'b000;
    // NaN of either sign goes to the positive limit, no overflow
    if (e == 8'hFF && bits[22:0] != 23'd0) begin
      flags = 3'b100;
      return F2I_POS_MAX;
    end
    if (e == 8'hFF) begin
      flags = 3'b101;
      return bits[31] ? F2I_NEG_MAX : F2I_POS_MAX;
    end
    if (e == 8'd0) begin
      mag = scale_pow2(real'(bits[22:0]), -149);
    end else begin
      mag = scale_pow2(real'({1'b1, bits[22:0]}), int'(e) - 150);
    end
    fl = $floor(mag);
    frac = mag - fl;
    if (cop == OP_F2I_RNE) begin
      // half rounds to the even neighbour
      if (frac > 0.5 || (frac == 0.5 && $floor(fl / 2.0) * 2.0 != fl)) begin
        fl = fl + 1.0;
      end
    end
    if (bits[31] ? (fl > INT_LIMIT) : (fl >= INT_LIMIT)) begin
      flags = 3'b101;
      return bits[31] ? F2I_NEG_MAX : F2I_POS_MAX;
    end
    flags[1] = (frac != 0.0);
    r = longint'(fl);
    r = bits[31] ? -r : r;
    return r[31:0];
  endfunction

  // integer value rounded to a 24-bit significand, nearest even
  function automatic logic [31:0] i2f_model(input logic [31:0] val, output logic [2:0] flags);
    real    v;
    real    mag;
    real    scaled;
    real    fl;
    real    frac;
    int     e;
    longint m;
    flags = 3'b000;
    if (val == 32'd0) begin
      return 32'd0;
    end
    v = real'($signed(val));
    mag = (v < 0.0) ? -v : v;
    e = 0;
    while (scale_pow2(1.0, e + 1) <= mag) e++;
    scaled = scale_pow2(mag, 23 - e);
    fl = $floor(scaled);
    frac = scaled - fl;
    m = longint'(fl);
    if (frac > 0.5 || (frac == 0.5 && m[0])) begin
      m++;
    end
    // rounding up to 2^24 moves into the next binade
    if (m == 64'd16777216) begin
      m = 64'd8388608;
      e++;
    end
    flags[1] = (frac != 0.0);
    return {val[31], 8'(e + 127), m[22:0]};
  endfunction

  //////////////////////////////
  // handshake
  //////////////////////////////

  // one request, optionally holding req high for a while after ack
  task automatic convert(input string name, input cvt_op_e cop, input logic [31:0] value,
                         input int hold);
    int edges;
    @(posedge clk);
    req <= 1'b1;
    op <= cop;
    operand <= value;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!ack && edges < ACK_TIMEOUT);
    if (!ack) begin
      $display("%s: ack never rose after the request", name);
      abort_run();
    end
    check_cycles({name, " ack rise"}, ACK_RISE_EDGES, edges);
    got_result = result;
    got_flags = {invalid, inexact, overflow};
    // back-pressure, everything must hold still
    repeat (hold) begin
      @(negedge clk);
      if (!ack) begin
        $display("%s: ack dropped while req was still high", name);
        abort_run();
      end
      check_result({name, " hold"}, got_result, result);
      check_flags({name, " hold"}, got_flags, {invalid, inexact, overflow});
    end
    @(posedge clk);
    req <= 1'b0;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (ack && edges < ACK_TIMEOUT);
    if (ack) begin
      $display("%s: ack stayed high after req was dropped", name);
      abort_run();
    end
    check_cycles({name, " ack fall"}, ACK_FALL_EDGES, edges);
  endtask

  task automatic expect_conv(input string name, input cvt_op_e cop, input logic [31:0] value,
                             input logic [31:0] exp_res, input logic [2:0] exp_flags);
    convert(name, cop, value, 0);
    check_result(name, exp_res, got_result);
    check_flags(name, exp_flags, got_flags);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_handshake();
    if (ack !== 1'b0) begin
      $display("ack_o is not low after reset");
      abort_run();
    end
    expect_conv("hs_one", OP_F2I_RNE, 32'h3F80_0000, 32'd1, 3'b000);
  endtask

  task automatic test_f2i_rne();
    expect_conv("rne_2p5", OP_F2I_RNE, 32'h4020_0000, 32'd2, 3'b010);
    expect_conv("rne_3p5", OP_F2I_RNE, 32'h4060_0000, 32'd4, 3'b010);
    expect_conv("rne_m1p5", OP_F2I_RNE, 32'hBFC0_0000, 32'hFFFF_FFFE, 3'b010);
    expect_conv("rne_0p5", OP_F2I_RNE, 32'h3F00_0000, 32'd0, 3'b010);
    expect_conv("rne_1p25", OP_F2I_RNE, 32'h3FA0_0000, 32'd1, 3'b010);
  endtask

  task automatic test_f2i_rtz();
    int          e;
    logic [31:0] bits;
    logic [31:0] exp_res;
    logic [2:0]  exp_flags;
    cvt_op_e     cop;
    expect_conv("rtz_2p9", OP_F2I_RTZ, 32'h4039_999A, 32'd2, 3'b010);
    expect_conv("rtz_m2p9", OP_F2I_RTZ, 32'hC039_999A, 32'hFFFF_FFFE, 3'b010);
    // exponents up to 2^30, always inside int32
    for (int i = 0; i < N_RAND; i++) begin
      e = int'($urandom_range(157, 100));
      bits = {1'($urandom), 8'(e), 23'($urandom)};
      cop = i[0] ? OP_F2I_RNE : OP_F2I_RTZ;
      exp_res = f2i_model(bits, cop, exp_flags);
      expect_conv($sformatf("f2i_rand_%0d", i), cop, bits, exp_res, exp_flags);
    end
  endtask

  task automatic test_saturation();
    expect_conv("sat_2p31", OP_F2I_RTZ, 32'h4F00_0000, F2I_POS_MAX, 3'b101);
    expect_conv("sat_m2p31", OP_F2I_RTZ, 32'hCF00_0000, F2I_NEG_MAX, 3'b000);
    expect_conv("sat_m2p32", OP_F2I_RNE, 32'hCF80_0000, F2I_NEG_MAX, 3'b101);
    expect_conv("sat_inf", OP_F2I_RNE, 32'h7F80_0000, F2I_POS_MAX, 3'b101);
    expect_conv("sat_qnan", OP_F2I_RNE, 32'h7FC0_0000, F2I_POS_MAX, 3'b100);
    expect_conv("sat_snan", OP_F2I_RTZ, 32'h7F80_0001, F2I_POS_MAX, 3'b100);
    expect_conv("sat_neg_qnan", OP_F2I_RTZ, 32'hFFC0_0000, F2I_POS_MAX, 3'b100);
  endtask

  task automatic test_i2f();
    logic [31:0] val;
    logic [31:0] exp_res;
    logic [2:0]  exp_flags;
    expect_conv("i2f_zero", OP_I2F, 32'd0, 32'h0000_0000, 3'b000);
    expect_conv("i2f_m1", OP_I2F, 32'hFFFF_FFFF, 32'hBF80_0000, 3'b000);
    expect_conv("i2f_2p24p1", OP_I2F, 32'd16777217, 32'h4B80_0000, 3'b010);
    expect_conv("i2f_max", OP_I2F, 32'h7FFF_FFFF, 32'h4F00_0000, 3'b010);
    expect_conv("i2f_min", OP_I2F, 32'h8000_0000, 32'hCF00_0000, 3'b000);
    // spread the magnitudes over all widths, odd runs negative
    for (int i = 0; i < N_RAND; i++) begin
      val = $urandom >> ($urandom % 32);
      if (i[0]) begin
        val = ~val + 32'd1;
      end
      exp_res = i2f_model(val, exp_flags);
      expect_conv($sformatf("i2f_rand_%0d", i), OP_I2F, val, exp_res, exp_flags);
    end
  endtask

  task automatic test_backpressure();
    convert("bp_hold", OP_F2I_RNE, 32'h4020_0000, HOLD_CYCLES);
    check_result("bp_hold", 32'd2, got_result);
    check_flags("bp_hold", 3'b010, got_flags);
    expect_conv("bp_next", OP_I2F, 32'hFFFF_FFFF, 32'hBF80_0000, 3'b000);
  endtask

  //////////////////////////////
  // run
  //////////////////////////////

  initial begin
    req = 1'b0;
    op = OP_F2I_RNE;
    operand = 32'd0;
    void'($urandom(SEED));
    wait (rst === 1'b0);
    @(negedge clk);
    test_handshake();
    test_f2i_rne();
    test_f2i_rtz();
    test_saturation();
    test_i2f();
    test_backpressure();
    $display("Simulation passed");
    $finish;
  end

  // generous budget per request, ends a hung handshake
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d clock cycles, the DUT stopped answering",
             WATCHDOG_CYCLES);
    abort_run();
  end

endmodule

`default_nettype wire
